// File: source/lsq_params.svh
// **********************************************************
// size macros for the load/store unit
// address and data widths, queue depths, cache geometry
// **********************************************************

`ifndef LSQ_PARAMS_SVH
`define LSQ_PARAMS_SVH

// word address and data word
`define LSQ_ADDR_W      32
`define LSQ_DATA_W      64

// store queue ring
`define LSQ_SQ_ENT      8
`define LSQ_SQ_IDX_W    3

// load queue ring
`define LSQ_LQ_ENT      4
`define LSQ_LQ_IDX_W    2
`define LSQ_TAG_W       4

// direct-mapped cache, one word per line
`define LSQ_DC_LINES    16
`define LSQ_DC_IDX_W    4
`define LSQ_MISS_DEPTH  4

`endif

// File: source/lsq_pkg.sv
// **********************************************************
// shared types of the load/store unit
// vector typedefs and the miss engine state
// **********************************************************

`include "lsq_params.svh"

package lsq_pkg;

	// word address
	typedef logic [`LSQ_ADDR_W-1:0] addr_t;

	// data word
	typedef logic [`LSQ_DATA_W-1:0] word_t;

	// store queue slot, and pointer with wrap bit
	typedef logic [`LSQ_SQ_IDX_W-1:0] sq_idx_t;
	typedef logic [`LSQ_SQ_IDX_W:0]   sq_ptr_t;

	// load queue pointer with wrap bit
	typedef logic [`LSQ_LQ_IDX_W:0] lq_ptr_t;

	// load identifier handed back on completion
	typedef logic [`LSQ_TAG_W-1:0] ld_tag_t;

	typedef enum logic {
		MISS_IDLE,
		MISS_WAIT
	} miss_state_t;

endpackage

// File: source/dcache_if.sv
// **********************************************************
// bus between the store queue, load queue and data cache
// **********************************************************

`include "lsq_params.svh"

interface dcache_if;

	// load lookup
	logic                   lk_vld;
	logic [`LSQ_ADDR_W-1:0] lk_addr;
	logic                   hit;
	logic [`LSQ_DATA_W-1:0] hit_data;

	// miss request uses lk_addr
	logic                   miss_push;
	logic                   miss_full;

	// fill broadcast
	logic                   fill_vld;
	logic [`LSQ_ADDR_W-1:0] fill_addr;
	logic [`LSQ_DATA_W-1:0] fill_data;

	// store drain, held until ack
	logic                   st_req;
	logic [`LSQ_ADDR_W-1:0] st_addr;
	logic [`LSQ_DATA_W-1:0] st_data;
	logic                   st_ack;

	modport sq_mp (output st_req, st_addr, st_data, input st_ack);

	modport lq_mp (output lk_vld, lk_addr, miss_push,
		input hit, hit_data, miss_full, fill_vld, fill_addr, fill_data);

	modport cache_mp (input lk_vld, lk_addr, miss_push, st_req, st_addr, st_data,
		output hit, hit_data, miss_full, fill_vld, fill_addr, fill_data, st_ack);

endinterface

// File: source/store_queue.sv
// **********************************************************
// store queue
// circular store ring with address valid and retire bits,
// load issue check, store to load forwarding, in-order drain
// **********************************************************

`include "lsq_params.svh"

module store_queue (
	input  logic              clk,
	input  logic              rst,
	input  logic              st_disp_i,
	input  logic              st_exec_i,
	input  logic              st_retire_i,
	input  lsq_pkg::sq_idx_t  st_sq_idx_i,
	input  lsq_pkg::addr_t    st_addr_i,
	input  lsq_pkg::word_t    st_data_i,
	input  logic              ld_vld_i,
	input  lsq_pkg::addr_t    ld_addr_i,
	input  lsq_pkg::sq_idx_t  ld_sq_pos_i,
	input  logic              lq_block_i,
	output lsq_pkg::sq_ptr_t  sq_tail_o,
	output logic              sq_full_o,
	output logic              ld_issue_ok_o,
	output logic              fwd_vld_o,
	output lsq_pkg::word_t    fwd_data_o,
	dcache_if.sq_mp           dc
);

	lsq_pkg::sq_ptr_t head_q;
	lsq_pkg::sq_ptr_t ret_q;
	lsq_pkg::sq_ptr_t tail_q;
	lsq_pkg::sq_idx_t head_idx;
	lsq_pkg::sq_idx_t ret_idx;
	lsq_pkg::sq_idx_t tail_idx;

	// slot storage
	lsq_pkg::addr_t sq_addr [`LSQ_SQ_ENT];
	lsq_pkg::word_t sq_data [`LSQ_SQ_ENT];
	logic [`LSQ_SQ_ENT-1:0] addr_vld;
	logic [`LSQ_SQ_ENT-1:0] ret_rdy;

	lsq_pkg::sq_idx_t    span;
	logic [`LSQ_SQ_IDX_W:0] older_cnt;
	logic                older_known;

	assign head_idx = head_q[`LSQ_SQ_IDX_W-1:0];
	assign ret_idx  = ret_q[`LSQ_SQ_IDX_W-1:0];
	assign tail_idx = tail_q[`LSQ_SQ_IDX_W-1:0];

	assign sq_tail_o = tail_q;
	assign sq_full_o = (head_idx == tail_idx) &&
		(head_q[`LSQ_SQ_IDX_W] != tail_q[`LSQ_SQ_IDX_W]);

	// **********************************************************
	// pointers and per-slot flags
	// **********************************************************
	always_ff @(posedge clk) begin
		if (rst) begin
			head_q   <= '0;
			ret_q    <= '0;
			tail_q   <= '0;
			addr_vld <= '0;
			ret_rdy  <= '0;
		end else begin
			if (st_disp_i) begin
				tail_q <= tail_q + 1'b1;
				addr_vld[tail_idx] <= 1'b0;
			end
			if (st_exec_i)
				addr_vld[st_sq_idx_i] <= 1'b1;
			if (st_retire_i) begin
				ret_q <= ret_q + 1'b1;
				ret_rdy[ret_idx] <= 1'b1;
			end
			// head store accepted by the cache
			if (dc.st_ack) begin
				head_q <= head_q + 1'b1;
				ret_rdy[head_idx]  <= 1'b0;
				addr_vld[head_idx] <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (st_exec_i) begin
			sq_addr[st_sq_idx_i] <= st_addr_i;
			sq_data[st_sq_idx_i] <= st_data_i;
		end
	end

	// **********************************************************
	// age walk for issue check and forwarding
	// **********************************************************

	// number of stores older than the load, all eight when full
	assign span = ld_sq_pos_i - head_idx;
	assign older_cnt = (sq_full_o && ld_sq_pos_i == head_idx) ?
		(`LSQ_SQ_IDX_W+1)'(`LSQ_SQ_ENT) : {1'b0, span};

	always_comb begin
		lsq_pkg::sq_idx_t slot;
		logic             is_older;
		older_known = 1'b1;
		fwd_vld_o   = 1'b0;
		fwd_data_o  = '0;
		// oldest first, so the last match is the youngest
		for (int k = 0; k < `LSQ_SQ_ENT; k++) begin
			slot     = head_idx + lsq_pkg::sq_idx_t'(k);
			is_older = (`LSQ_SQ_IDX_W+1)'(k) < older_cnt;
			if (is_older && !addr_vld[slot])
				older_known = 1'b0;
			if (is_older && addr_vld[slot] && sq_addr[slot] == ld_addr_i) begin
				fwd_vld_o  = ld_vld_i;
				fwd_data_o = sq_data[slot];
			end
		end
	end

	assign ld_issue_ok_o = older_known && !lq_block_i;

	// drain the head once it has retired
	assign dc.st_req  = ret_rdy[head_idx];
	assign dc.st_addr = sq_addr[head_idx];
	assign dc.st_data = sq_data[head_idx];

endmodule

// File: source/load_queue.sv
// **********************************************************
// load queue
// hit, forward or miss choice, miss entries waiting on
// fills, in-order completion and the result register
// **********************************************************

`include "lsq_params.svh"

module load_queue (
	input  logic             clk,
	input  logic             rst,
	input  logic             ld_vld_i,
	input  lsq_pkg::addr_t   ld_addr_i,
	input  lsq_pkg::ld_tag_t ld_tag_i,
	input  logic             fwd_vld_i,
	input  lsq_pkg::word_t   fwd_data_i,
	output logic             lq_block_o,
	output logic             ld_done_o,
	output lsq_pkg::ld_tag_t ld_done_tag_o,
	output lsq_pkg::word_t   ld_done_data_o,
	dcache_if.lq_mp          dc
);

	lsq_pkg::lq_ptr_t head_q;
	lsq_pkg::lq_ptr_t tail_q;
	logic [`LSQ_LQ_IDX_W-1:0] head_idx;
	logic [`LSQ_LQ_IDX_W-1:0] tail_idx;

	// miss entries
	lsq_pkg::addr_t   lq_addr [`LSQ_LQ_ENT];
	lsq_pkg::ld_tag_t lq_tag [`LSQ_LQ_ENT];
	lsq_pkg::word_t   lq_data [`LSQ_LQ_ENT];
	logic [`LSQ_LQ_ENT-1:0] lq_vld;
	logic [`LSQ_LQ_ENT-1:0] lq_rdy;
	logic [`LSQ_LQ_ENT-1:0] fill_match;

	logic lq_full;
	logic ld_miss;
	logic head_rdy;

	assign head_idx = head_q[`LSQ_LQ_IDX_W-1:0];
	assign tail_idx = tail_q[`LSQ_LQ_IDX_W-1:0];
	assign lq_full  = (head_idx == tail_idx) &&
		(head_q[`LSQ_LQ_IDX_W] != tail_q[`LSQ_LQ_IDX_W]);
	assign head_rdy = lq_vld[head_idx] && lq_rdy[head_idx];

	// every load looks up the cache, forwarding wins over a hit
	assign dc.lk_vld    = ld_vld_i;
	assign dc.lk_addr   = ld_addr_i;
	assign ld_miss      = ld_vld_i && !fwd_vld_i && !dc.hit;
	assign dc.miss_push = ld_miss;

	assign lq_block_o = lq_full || dc.miss_full || head_rdy || dc.fill_vld;

	// only waiting entries take a fill
	always_comb begin
		for (int k = 0; k < `LSQ_LQ_ENT; k++)
			fill_match[k] = dc.fill_vld && lq_vld[k] && !lq_rdy[k] &&
				lq_addr[k] == dc.fill_addr;
	end

	// **********************************************************
	// entry control
	// **********************************************************
	always_ff @(posedge clk) begin
		if (rst) begin
			head_q <= '0;
			tail_q <= '0;
			lq_vld <= '0;
			lq_rdy <= '0;
		end else begin
			lq_rdy <= lq_rdy | fill_match;
			if (ld_miss) begin
				tail_q <= tail_q + 1'b1;
				lq_vld[tail_idx] <= 1'b1;
				lq_rdy[tail_idx] <= 1'b0;
			end
			if (head_rdy) begin
				head_q <= head_q + 1'b1;
				lq_vld[head_idx] <= 1'b0;
				lq_rdy[head_idx] <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (ld_miss) begin
			lq_addr[tail_idx] <= ld_addr_i;
			lq_tag[tail_idx]  <= ld_tag_i;
		end
		for (int k = 0; k < `LSQ_LQ_ENT; k++) begin
			if (fill_match[k])
				lq_data[k] <= dc.fill_data;
		end
	end

	// **********************************************************
	// result register
	// **********************************************************

	// issue is blocked while the head is ready, so never both
	always_ff @(posedge clk) begin
		if (rst)
			ld_done_o <= 1'b0;
		else
			ld_done_o <= head_rdy || (ld_vld_i && !ld_miss);
	end

	always_ff @(posedge clk) begin
		if (head_rdy) begin
			ld_done_tag_o  <= lq_tag[head_idx];
			ld_done_data_o <= lq_data[head_idx];
		end else if (ld_vld_i) begin
			ld_done_tag_o  <= ld_tag_i;
			ld_done_data_o <= fwd_vld_i ? fwd_data_i : dc.hit_data;
		end
	end

endmodule

// File: source/dcache.sv
// **********************************************************
// data cache
// direct-mapped tag and data arrays, miss FIFO,
// single outstanding read engine, write-through stores
// **********************************************************

`include "lsq_params.svh"

module dcache (
	input  logic            clk,
	input  logic            rst,
	dcache_if.cache_mp      dc,
	output logic            mem_rd_o,
	output lsq_pkg::addr_t  mem_rd_addr_o,
	input  logic            mem_rsp_i,
	input  lsq_pkg::word_t  mem_rsp_data_i,
	output logic            mem_wr_o,
	output lsq_pkg::addr_t  mem_wr_addr_o,
	output lsq_pkg::word_t  mem_wr_data_o
);

	// line storage
	logic [`LSQ_DC_LINES-1:0] dc_vld;
	logic [`LSQ_ADDR_W-`LSQ_DC_IDX_W-1:0] dc_tag [`LSQ_DC_LINES];
	lsq_pkg::word_t dc_data [`LSQ_DC_LINES];

	logic [`LSQ_DC_IDX_W-1:0] lk_idx;
	logic [`LSQ_DC_IDX_W-1:0] st_idx;
	logic [`LSQ_DC_IDX_W-1:0] fill_idx;
	logic st_hit;

	// miss FIFO with wrap bits
	lsq_pkg::addr_t mf_addr [`LSQ_MISS_DEPTH];
	logic [$clog2(`LSQ_MISS_DEPTH):0] mf_wr;
	logic [$clog2(`LSQ_MISS_DEPTH):0] mf_rd;
	logic [$clog2(`LSQ_MISS_DEPTH)-1:0] mf_wr_idx;
	logic [$clog2(`LSQ_MISS_DEPTH)-1:0] mf_rd_idx;
	logic mf_empty;
	logic rd_start;

	lsq_pkg::miss_state_t state;
	lsq_pkg::addr_t rd_addr_q;
	lsq_pkg::word_t fill_data_q;
	logic fill_vld_q;

	assign lk_idx   = dc.lk_addr[`LSQ_DC_IDX_W-1:0];
	assign st_idx   = dc.st_addr[`LSQ_DC_IDX_W-1:0];
	assign fill_idx = rd_addr_q[`LSQ_DC_IDX_W-1:0];

	assign dc.hit = dc.lk_vld && dc_vld[lk_idx] &&
		dc_tag[lk_idx] == dc.lk_addr[`LSQ_ADDR_W-1:`LSQ_DC_IDX_W];
	assign dc.hit_data = dc_data[lk_idx];

	assign mf_wr_idx    = mf_wr[$clog2(`LSQ_MISS_DEPTH)-1:0];
	assign mf_rd_idx    = mf_rd[$clog2(`LSQ_MISS_DEPTH)-1:0];
	assign mf_empty     = mf_wr == mf_rd;
	assign dc.miss_full = (mf_wr_idx == mf_rd_idx) &&
		(mf_wr[$clog2(`LSQ_MISS_DEPTH)] != mf_rd[$clog2(`LSQ_MISS_DEPTH)]);
	assign rd_start     = state == lsq_pkg::MISS_IDLE && !mf_empty;

	assign dc.fill_vld  = fill_vld_q;
	assign dc.fill_addr = rd_addr_q;
	assign dc.fill_data = fill_data_q;

	// **********************************************************
	// read engine
	// **********************************************************
	always_ff @(posedge clk) begin
		if (rst) begin
			state      <= lsq_pkg::MISS_IDLE;
			mf_wr      <= '0;
			mf_rd      <= '0;
			mem_rd_o   <= 1'b0;
			fill_vld_q <= 1'b0;
			dc_vld     <= '0;
		end else begin
			mem_rd_o   <= rd_start;
			fill_vld_q <= state == lsq_pkg::MISS_WAIT && mem_rsp_i;
			if (dc.miss_push)
				mf_wr <= mf_wr + 1'b1;
			case (state)
				lsq_pkg::MISS_IDLE: begin
					if (!mf_empty) begin
						mf_rd <= mf_rd + 1'b1;
						state <= lsq_pkg::MISS_WAIT;
					end
				end
				lsq_pkg::MISS_WAIT: begin
					if (mem_rsp_i)
						state <= lsq_pkg::MISS_IDLE;
				end
				default: state <= lsq_pkg::MISS_IDLE;
			endcase
			// line becomes valid in the broadcast cycle
			if (fill_vld_q)
				dc_vld[fill_idx] <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (dc.miss_push)
			mf_addr[mf_wr_idx] <= dc.lk_addr;
		if (rd_start)
			rd_addr_q <= mf_addr[mf_rd_idx];
		if (state == lsq_pkg::MISS_WAIT && mem_rsp_i)
			fill_data_q <= mem_rsp_data_i;
		if (fill_vld_q) begin
			dc_tag[fill_idx]  <= rd_addr_q[`LSQ_ADDR_W-1:`LSQ_DC_IDX_W];
			dc_data[fill_idx] <= fill_data_q;
		end
		if (dc.st_ack && st_hit)
			dc_data[st_idx] <= dc.st_data;
	end

	assign mem_rd_addr_o = rd_addr_q;

	// **********************************************************
	// write-through store path, no allocate
	// **********************************************************
	assign st_hit = dc_vld[st_idx] &&
		dc_tag[st_idx] == dc.st_addr[`LSQ_ADDR_W-1:`LSQ_DC_IDX_W];

	// hold the store back until all misses are filled
	assign dc.st_ack = dc.st_req && mf_empty && state == lsq_pkg::MISS_IDLE &&
		!fill_vld_q && !dc.miss_push;

	assign mem_wr_o      = dc.st_ack;
	assign mem_wr_addr_o = dc.st_addr;
	assign mem_wr_data_o = dc.st_data;

endmodule

// File: source/lsq_top.sv
// **********************************************************
// load/store unit top level
// store queue, load queue and data cache on one bus
// **********************************************************

`include "lsq_params.svh"

module lsq_top (
	input  logic             clk,
	input  logic             rst,
	input  logic             st_disp_i,
	input  logic             st_exec_i,
	input  logic             st_retire_i,
	input  lsq_pkg::sq_idx_t st_sq_idx_i,
	input  lsq_pkg::addr_t   st_addr_i,
	input  lsq_pkg::word_t   st_data_i,
	input  logic             ld_vld_i,
	input  lsq_pkg::addr_t   ld_addr_i,
	input  lsq_pkg::sq_idx_t ld_sq_pos_i,
	input  lsq_pkg::ld_tag_t ld_tag_i,
	output lsq_pkg::sq_ptr_t sq_tail_o,
	output logic             sq_full_o,
	output logic             ld_issue_ok_o,
	output logic             ld_done_o,
	output lsq_pkg::ld_tag_t ld_done_tag_o,
	output lsq_pkg::word_t   ld_done_data_o,
	output logic             mem_rd_o,
	output lsq_pkg::addr_t   mem_rd_addr_o,
	input  logic             mem_rsp_i,
	input  lsq_pkg::word_t   mem_rsp_data_i,
	output logic             mem_wr_o,
	output lsq_pkg::addr_t   mem_wr_addr_o,
	output lsq_pkg::word_t   mem_wr_data_o
);

	logic           fwd_vld;
	lsq_pkg::word_t fwd_data;
	logic           lq_block;

	dcache_if dc_bus ();

	store_queue i_store_queue (
		.clk           (clk),
		.rst           (rst),
		.st_disp_i     (st_disp_i),
		.st_exec_i     (st_exec_i),
		.st_retire_i   (st_retire_i),
		.st_sq_idx_i   (st_sq_idx_i),
		.st_addr_i     (st_addr_i),
		.st_data_i     (st_data_i),
		.ld_vld_i      (ld_vld_i),
		.ld_addr_i     (ld_addr_i),
		.ld_sq_pos_i   (ld_sq_pos_i),
		.lq_block_i    (lq_block),
		.sq_tail_o     (sq_tail_o),
		.sq_full_o     (sq_full_o),
		.ld_issue_ok_o (ld_issue_ok_o),
		.fwd_vld_o     (fwd_vld),
		.fwd_data_o    (fwd_data),
		.dc            (dc_bus.sq_mp)
	);

	load_queue i_load_queue (
		.clk            (clk),
		.rst            (rst),
		.ld_vld_i       (ld_vld_i),
		.ld_addr_i      (ld_addr_i),
		.ld_tag_i       (ld_tag_i),
		.fwd_vld_i      (fwd_vld),
		.fwd_data_i     (fwd_data),
		.lq_block_o     (lq_block),
		.ld_done_o      (ld_done_o),
		.ld_done_tag_o  (ld_done_tag_o),
		.ld_done_data_o (ld_done_data_o),
		.dc             (dc_bus.lq_mp)
	);

	dcache i_dcache (
		.clk            (clk),
		.rst            (rst),
		.dc             (dc_bus.cache_mp),
		.mem_rd_o       (mem_rd_o),
		.mem_rd_addr_o  (mem_rd_addr_o),
		.mem_rsp_i      (mem_rsp_i),
		.mem_rsp_data_i (mem_rsp_data_i),
		.mem_wr_o       (mem_wr_o),
		.mem_wr_addr_o  (mem_wr_addr_o),
		.mem_wr_data_o  (mem_wr_data_o)
	);

endmodule

// File: tb/lsq_tests.svh
// **********************************************************
// stimulus helpers and directed tests for the load/store unit
// **********************************************************

task automatic expect_equal(input string test, input string what,
	input logic [63:0] exp, input logic [63:0] act);
	assert (act === exp)
	else report_error($sformatf("Fail %s: %s expected %0h actual %0h",
		test, what, exp, act));
endtask

task automatic wait_done(input string test, input int count, input int limit);
	int cycles;
	cycles = 0;
	while (done_tag_q.size() < count) begin
		assert (cycles < limit)
		else report_error($sformatf("%s: a load did not complete within %0d cycles",
			test, limit));
		@(negedge clk);
		cycles++;
	end
endtask

task automatic wait_writes(input string test, input int count, input int limit);
	int cycles;
	cycles = 0;
	while (wr_addr_q.size() < count) begin
		assert (cycles < limit)
		else report_error($sformatf("%s: a store did not reach memory within %0d cycles",
			test, limit));
		@(negedge clk);
		cycles++;
	end
endtask

task automatic dispatch_store();
	@(negedge clk);
	st_disp_i = 1'b1;
	@(negedge clk);
	st_disp_i = 1'b0;
	sq_tail   = sq_tail + 1'b1;
endtask

task automatic execute_store(input lsq_pkg::sq_idx_t idx, input lsq_pkg::addr_t addr,
	input lsq_pkg::word_t data);
	@(negedge clk);
	st_exec_i   = 1'b1;
	st_sq_idx_i = idx;
	st_addr_i   = addr;
	st_data_i   = data;
	@(negedge clk);
	st_exec_i = 1'b0;
endtask

task automatic retire_store();
	@(negedge clk);
	st_retire_i = 1'b1;
	@(negedge clk);
	st_retire_i = 1'b0;
endtask

// load is younger than every store dispatched so far
task automatic issue_load(input lsq_pkg::addr_t addr, input lsq_pkg::ld_tag_t tag);
	int waited;
	waited = 0;
	@(negedge clk);
	ld_sq_pos_i = sq_tail[`LSQ_SQ_IDX_W-1:0];
	ld_addr_i   = addr;
	ld_tag_i    = tag;
	@(negedge clk);
	while (!ld_issue_ok_o) begin
		assert (waited < 60)
		else report_error("a load was never allowed to issue");
		@(negedge clk);
		waited++;
	end
	ld_vld_i = 1'b1;
	@(negedge clk);
	ld_vld_i = 1'b0;
endtask

// **********************************************************
// directed tests
// **********************************************************
task automatic check_after_reset();
	@(negedge clk);
	expect_equal("reset", "sq_tail_o", 64'(0), 64'(sq_tail_o));
	expect_equal("reset", "sq_full_o", 64'(0), 64'(sq_full_o));
	expect_equal("reset", "ld_done_o", 64'(0), 64'(ld_done_o));
	expect_equal("reset", "mem_rd_o", 64'(0), 64'(mem_rd_o));
	expect_equal("reset", "mem_wr_o", 64'(0), 64'(mem_wr_o));
	expect_equal("reset", "ld_issue_ok_o", 64'(1), 64'(ld_issue_ok_o));
endtask

task automatic miss_then_hit();
	lsq_pkg::addr_t addr;
	int done_base;
	int rd_base;
	addr      = 32'd9;
	done_base = done_tag_q.size();
	rd_base   = rd_log.size();
	issue_load(addr, 4'd1);
	wait_done("miss_hit", done_base + 1, 40);
	expect_equal("miss_hit", "read count", 64'(rd_base + 1), 64'(rd_log.size()));
	expect_equal("miss_hit", "read address", 64'(addr), 64'(rd_log[rd_base]));
	expect_equal("miss_hit", "miss tag", 64'(1), 64'(done_tag_q[done_base]));
	expect_equal("miss_hit", "miss data", ref_mem[addr[5:0]], done_data_q[done_base]);
	// same line again, one cycle and no read
	issue_load(addr, 4'd2);
	wait_done("miss_hit", done_base + 2, 1);
	expect_equal("miss_hit", "hit tag", 64'(2), 64'(done_tag_q[done_base + 1]));
	expect_equal("miss_hit", "hit data", ref_mem[addr[5:0]], done_data_q[done_base + 1]);
	// a stray miss would have sent its read by now
	repeat (3) @(negedge clk);
	expect_equal("miss_hit", "read count after hit", 64'(rd_base + 1), 64'(rd_log.size()));
endtask

task automatic gating_and_forwarding();
	lsq_pkg::sq_idx_t first;
	int done_base;
	int rd_base;
	int wr_base;
	first     = sq_tail[`LSQ_SQ_IDX_W-1:0];
	done_base = done_tag_q.size();
	rd_base   = rd_log.size();
	wr_base   = wr_addr_q.size();
	dispatch_store();
	expect_equal("issue_fwd", "sq_tail_o", 64'(sq_tail), 64'(sq_tail_o));
	@(negedge clk);
	ld_sq_pos_i = sq_tail[`LSQ_SQ_IDX_W-1:0];
	repeat (3) begin
		@(negedge clk);
		expect_equal("issue_fwd", "ld_issue_ok_o before execute", 64'(0), 64'(ld_issue_ok_o));
	end
	execute_store(first, 32'd20, 64'h1111_2222_3333_4444);
	expect_equal("issue_fwd", "ld_issue_ok_o after execute", 64'(1), 64'(ld_issue_ok_o));
	dispatch_store();
	execute_store(lsq_pkg::sq_idx_t'(first + 1'b1), 32'd20, 64'h5555_6666_7777_8888);
	issue_load(32'd20, 4'd3);
	wait_done("issue_fwd", done_base + 1, 1);
	expect_equal("issue_fwd", "tag", 64'(3), 64'(done_tag_q[done_base]));
	expect_equal("issue_fwd", "forwarded data", 64'h5555_6666_7777_8888,
		done_data_q[done_base]);
	repeat (3) @(negedge clk);
	expect_equal("issue_fwd", "read count", 64'(rd_base), 64'(rd_log.size()));
	retire_store();
	retire_store();
	wait_writes("issue_fwd", wr_base + 2, 40);
	expect_equal("issue_fwd", "first write address", 64'(20), 64'(wr_addr_q[wr_base]));
	expect_equal("issue_fwd", "first write data", 64'h1111_2222_3333_4444,
		wr_data_q[wr_base]);
	expect_equal("issue_fwd", "second write address", 64'(20), 64'(wr_addr_q[wr_base + 1]));
	expect_equal("issue_fwd", "second write data", 64'h5555_6666_7777_8888,
		wr_data_q[wr_base + 1]);
endtask

task automatic drain_order_and_full();
	lsq_pkg::sq_idx_t first;
	int wr_base;
	int done_base;
	first     = sq_tail[`LSQ_SQ_IDX_W-1:0];
	wr_base   = wr_addr_q.size();
	done_base = done_tag_q.size();
	for (int k = 0; k < `LSQ_SQ_ENT; k++) begin
		expect_equal("drain_full", "sq_full_o while filling", 64'(0), 64'(sq_full_o));
		dispatch_store();
	end
	expect_equal("drain_full", "sq_full_o", 64'(1), 64'(sq_full_o));
	expect_equal("drain_full", "sq_tail_o", 64'(sq_tail), 64'(sq_tail_o));
	for (int k = 0; k < `LSQ_SQ_ENT; k++)
		execute_store(lsq_pkg::sq_idx_t'(first + k), lsq_pkg::addr_t'(32 + k), st_vals[k]);
	for (int k = 0; k < `LSQ_SQ_ENT; k++)
		retire_store();
	wait_writes("drain_full", wr_base + `LSQ_SQ_ENT, 100);
	for (int k = 0; k < `LSQ_SQ_ENT; k++) begin
		expect_equal("drain_full", "write address", 64'(32 + k), 64'(wr_addr_q[wr_base + k]));
		expect_equal("drain_full", "write data", st_vals[k], wr_data_q[wr_base + k]);
	end
	expect_equal("drain_full", "sq_full_o after drain", 64'(0), 64'(sq_full_o));
	// stored word comes back through a miss
	issue_load(32'd35, 4'd5);
	wait_done("drain_full", done_base + 1, 40);
	expect_equal("drain_full", "tag", 64'(5), 64'(done_tag_q[done_base]));
	expect_equal("drain_full", "loaded data", st_vals[3], done_data_q[done_base]);
endtask

task automatic several_misses();
	lsq_pkg::addr_t addr;
	int done_base;
	int rd_base;
	done_base = done_tag_q.size();
	rd_base   = rd_log.size();
	for (int k = 0; k < 6; k++)
		issue_load(lsq_pkg::addr_t'(48 + k), lsq_pkg::ld_tag_t'(8 + k));
	wait_done("multi_miss", done_base + 6, 200);
	expect_equal("multi_miss", "read count", 64'(rd_base + 6), 64'(rd_log.size()));
	for (int k = 0; k < 6; k++) begin
		addr = lsq_pkg::addr_t'(48 + k);
		expect_equal("multi_miss", "read address", 64'(addr), 64'(rd_log[rd_base + k]));
		expect_equal("multi_miss", "tag", 64'(8 + k), 64'(done_tag_q[done_base + k]));
		expect_equal("multi_miss", "data", ref_mem[addr[5:0]], done_data_q[done_base + k]);
	end
endtask

// File: tb/tb_lsq_top.sv
// **********************************************************
// testbench for the load/store unit
// clock, reset, DUT, LFSR, memory model, watchdog, tests
// **********************************************************

`include "lsq_params.svh"

module tb_lsq_top;

	localparam int NUM_TESTS   = 5;
	localparam int TEST_CYCLES = 500;
	localparam int MEM_WORDS   = 64;

	logic             clk;
	logic             rst;
	logic             st_disp_i;
	logic             st_exec_i;
	logic             st_retire_i;
	lsq_pkg::sq_idx_t st_sq_idx_i;
	lsq_pkg::addr_t   st_addr_i;
	lsq_pkg::word_t   st_data_i;
	logic             ld_vld_i;
	lsq_pkg::addr_t   ld_addr_i;
	lsq_pkg::sq_idx_t ld_sq_pos_i;
	lsq_pkg::ld_tag_t ld_tag_i;
	lsq_pkg::sq_ptr_t sq_tail_o;
	logic             sq_full_o;
	logic             ld_issue_ok_o;
	logic             ld_done_o;
	lsq_pkg::ld_tag_t ld_done_tag_o;
	lsq_pkg::word_t   ld_done_data_o;
	logic             mem_rd_o;
	lsq_pkg::addr_t   mem_rd_addr_o;
	logic             mem_rsp_i;
	lsq_pkg::word_t   mem_rsp_data_i;
	logic             mem_wr_o;
	lsq_pkg::addr_t   mem_wr_addr_o;
	lsq_pkg::word_t   mem_wr_data_o;

	// reference memory and store values
	lsq_pkg::word_t ref_mem [MEM_WORDS];
	lsq_pkg::word_t st_vals [`LSQ_SQ_ENT];
	logic [31:0]    lfsr;

	// scheduler view of the store queue tail
	lsq_pkg::sq_ptr_t sq_tail;

	// observed DUT events, in arrival order
	lsq_pkg::ld_tag_t done_tag_q [$];
	lsq_pkg::word_t   done_data_q [$];
	lsq_pkg::addr_t   rd_log [$];
	lsq_pkg::addr_t   wr_addr_q [$];
	lsq_pkg::word_t   wr_data_q [$];
	int               rsp_idx;

	lsq_top i_lsq_top (.*);

	task automatic report_error(input string msg);
		$display("%s", msg);
		$display("TESTBENCH FAILED");
		$fatal(1, "simulation stopped at the first error");
	endtask

	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		logic [31:0] n;
		n = s >> 1;
		if (s[0])
			n = n ^ 32'h8020_0003;
		return n;
	endfunction

	function automatic lsq_pkg::word_t take_bits(input int count);
		lsq_pkg::word_t v;
		v = '0;
		for (int i = 0; i < count; i++) begin
			lfsr = lfsr_step(lfsr);
			v = {v[62:0], lfsr[0]};
		end
		return v;
	endfunction

	`include "lsq_tests.svh"

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// **********************************************************
	// memory model and event monitor
	// **********************************************************
	initial begin
		int delay;
		delay          = 0;
		rsp_idx        = 0;
		mem_rsp_i      = 1'b0;
		mem_rsp_data_i = '0;
		lfsr           = 32'hae8a_face;
		for (int a = 0; a < MEM_WORDS; a++)
			ref_mem[a] = take_bits(64);
		for (int k = 0; k < `LSQ_SQ_ENT; k++)
			st_vals[k] = take_bits(64);
		forever begin
			// outputs of the cycle that just ended
			@(posedge clk);
			if (!rst) begin
				if (ld_done_o) begin
					done_tag_q.push_back(ld_done_tag_o);
					done_data_q.push_back(ld_done_data_o);
				end
				if (mem_rd_o)
					rd_log.push_back(mem_rd_addr_o);
				if (mem_wr_o) begin
					wr_addr_q.push_back(mem_wr_addr_o);
					wr_data_q.push_back(mem_wr_data_o);
					ref_mem[mem_wr_addr_o[5:0]] = mem_wr_data_o;
				end
			end
			@(negedge clk);
			mem_rsp_i = 1'b0;
			// reads answered in order, 1 to 4 cycles late
			if (delay == 0 && rsp_idx < rd_log.size())
				delay = int'(take_bits(2)) + 1;
			if (delay > 0) begin
				delay--;
				if (delay == 0) begin
					mem_rsp_data_i = ref_mem[rd_log[rsp_idx][5:0]];
					mem_rsp_i      = 1'b1;
					rsp_idx++;
				end
			end
		end
	end

	initial begin
		repeat (NUM_TESTS * TEST_CYCLES) @(posedge clk);
		report_error("watchdog: the tests did not finish within the cycle limit");
	end

	// **********************************************************
	// test sequence
	// **********************************************************
	initial begin
		rst         = 1'b1;
		st_disp_i   = 1'b0;
		st_exec_i   = 1'b0;
		st_retire_i = 1'b0;
		st_sq_idx_i = '0;
		st_addr_i   = '0;
		st_data_i   = '0;
		ld_vld_i    = 1'b0;
		ld_addr_i   = '0;
		ld_sq_pos_i = '0;
		ld_tag_i    = '0;
		sq_tail     = '0;
		repeat (2) @(negedge clk);
		rst = 1'b0;
		check_after_reset();
		miss_then_hit();
		gating_and_forwarding();
		drain_order_and_full();
		several_misses();
		$display("TESTBENCH PASSED");
		$finish;
	end

endmodule

// File: flist.f
+incdir+source
+incdir+tb
source/lsq_pkg.sv
source/dcache_if.sv
source/store_queue.sv
source/load_queue.sv
source/dcache.sv
source/lsq_top.sv
tb/tb_lsq_top.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the load/store unit testbench with Verilator
set -e
cd "$(dirname "$0")"
rm -rf obj_dir sim.log
verilator --binary --timing --assert -f flist.f --top-module tb_lsq_top -o tb_lsq_top
./obj_dir/tb_lsq_top | tee sim.log
if grep -q "TESTBENCH PASSED" sim.log; then
	echo "simulation passed"
else
	echo "simulation failed, see sim.log"
	exit 1
fi
